// ==== flist.f ====
verilog/mem_pkg.sv
verilog/pipe_reg.sv
verilog/mem_access_decode.sv
verilog/line_cache.sv
verilog/mem_stage.sv
verif/host_mem_model.sv
verif/tb_mem_stage.sv

// ==== verif/host_mem_model.sv ====
`default_nettype none

module host_mem_model (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire mem_pkg::host_req_t host_req,
	output logic [mem_pkg::line_w-1:0] host_rdata,
	output logic host_tx_done,
	output logic host_rd_valid,
	output int read_count,
	output int write_count,
	output logic [31:0] last_waddr,
	output logic [mem_pkg::line_w-1:0] last_wline,
	output int err_count
);
	timeunit 1ns;
	timeprecision 100ps;

	// only written lines are stored, the rest read as the fill pattern
	logic [mem_pkg::line_w-1:0] mem [int unsigned];
	mem_pkg::host_req_t req_q;
	logic busy;
	int unsigned wait_cnt;
	logic [25:0] q_line;

	// line number of the open transaction, 64 bytes per line
	assign q_line = req_q.addr[31:6];

	// word i of line L holds (L*16+i) xor 5a5a_0000
	function automatic logic [mem_pkg::line_w-1:0] fetch_line(input int unsigned line_no);
		logic [mem_pkg::line_w-1:0] line;
		int i;
		if (mem.exists(line_no)) begin
			return mem[line_no];
		end
		for (i = 0; i < mem_pkg::words_per_line; i++) begin
			line[i * mem_pkg::word_w +: mem_pkg::word_w] = (line_no * 16 + i) ^ 32'h5a5a_0000;
		end
		return line;
	endfunction

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			wait_cnt <= 0;
			host_tx_done <= 1'b0;
			host_rd_valid <= 1'b0;
			host_rdata <= '0;
			read_count <= 0;
			write_count <= 0;
			last_waddr <= '0;
			last_wline <= '0;
			err_count <= 0;
		end else begin
			// done and read valid are single-cycle
			host_tx_done <= 1'b0;
			host_rd_valid <= 1'b0;
			if (busy) begin
				// op, address and data frozen until done
				assert (host_req == req_q) else begin
					$display("[ERROR] %0t ns host_req.addr expected %h got %h (op %0d, now %0d)",
						$time, req_q.addr, host_req.addr, req_q.op, host_req.op);
					err_count <= err_count + 1;
				end
				if (host_tx_done) begin
					// cache leaves the transaction at this edge
					busy <= 1'b0;
				end else if (wait_cnt <= 1) begin
					host_tx_done <= 1'b1;
					if (req_q.op == mem_pkg::host_read) begin
						host_rdata <= fetch_line(q_line);
						host_rd_valid <= 1'b1;
						read_count <= read_count + 1;
					end else begin
						mem[q_line] = req_q.data;
						last_waddr <= req_q.addr;
						last_wline <= req_q.data;
						write_count <= write_count + 1;
					end
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end else if (host_req.op != mem_pkg::host_none) begin
				// new transaction, latency 2 to 6 cycles
				busy <= 1'b1;
				req_q <= host_req;
				wait_cnt <= 2 + $urandom % 5;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_mem_stage.sv ====
`default_nettype none

module tb_mem_stage;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] fpu_addr = 32'h1000_0000;
	localparam int timeout_cycles = 300;

	logic clk;
	logic arst_n;
	logic req_valid;
	logic req_ready;
	mem_pkg::mem_req_t req;
	logic resp_valid;
	logic resp_ready;
	mem_pkg::mem_result_t resp;
	mem_pkg::host_req_t host_req;
	logic [mem_pkg::line_w-1:0] host_rdata;
	logic host_tx_done;
	logic host_rd_valid;
	logic start_fpu;
	int read_count;
	int write_count;
	int host_errs;
	logic [31:0] last_waddr;
	logic [mem_pkg::line_w-1:0] last_wline;

	int errors = 0;
	int checks = 0;
	int fpu_pulses = 0;
	// expected and observed results in request order
	mem_pkg::mem_result_t exp_q[$];
	mem_pkg::mem_result_t got_q[$];
	// words written so far by word index
	logic [31:0] shadow [int unsigned];

	mem_stage #(
		.num_lines(4),
		.fpu_start_addr(fpu_addr)
	) u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req(req),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.resp(resp),
		.host_req(host_req),
		.host_rdata(host_rdata),
		.host_tx_done(host_tx_done),
		.host_rd_valid(host_rd_valid),
		.start_fpu(start_fpu)
	);

	host_mem_model u_host (
		.clk(clk),
		.arst_n(arst_n),
		.host_req(host_req),
		.host_rdata(host_rdata),
		.host_tx_done(host_tx_done),
		.host_rd_valid(host_rd_valid),
		.read_count(read_count),
		.write_count(write_count),
		.last_waddr(last_waddr),
		.last_wline(last_wline),
		.err_count(host_errs)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// sampled mid-cycle before the edge that completes a transfer
	always @(negedge clk) begin
		if (arst_n) begin
			if (resp_valid && resp_ready) begin
				got_q.push_back(resp);
			end
			if (start_fpu) begin
				fpu_pulses++;
			end
		end
	end

	// word index is L*16+i so the pattern word is index xor 5a5a_0000
	function automatic logic [31:0] shadow_word(input logic [31:0] addr);
		int unsigned idx;
		idx = addr[31:2];
		if (shadow.exists(idx)) begin
			return shadow[idx];
		end
		return idx ^ 32'h5a5a_0000;
	endfunction

	task automatic finish_run();
		$display("checks %0d, errors %0d, host model errors %0d, host reads %0d, host writes %0d",
			checks, errors, host_errs, read_count, write_count);
		if (errors == 0 && host_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		errors++;
		finish_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// starts 1 ns after an edge and returns 1 ns after the accepting edge
	task automatic send_req(input logic [31:0] addr, input logic [31:0] wdata, input logic write);
		mem_pkg::mem_result_t exp;
		logic is_ctrl;
		int waited;
		is_ctrl = addr[31:2] == fpu_addr[31:2];
		exp.write = write;
		exp.rdata = (is_ctrl || write) ? 32'h0 : shadow_word(addr);
		if (write && !is_ctrl) begin
			shadow[addr[31:2]] = wdata;
		end
		exp_q.push_back(exp);
		req.addr = addr;
		req.wdata = wdata;
		req.write = write;
		req_valid = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!req_ready && waited < timeout_cycles) begin
			waited++;
			@(negedge clk);
		end
		if (!req_ready) begin
			fail_timeout("req_ready");
		end
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	// drain all results and compare them in order
	task automatic expect_results();
		mem_pkg::mem_result_t exp;
		mem_pkg::mem_result_t got;
		int waited;
		waited = 0;
		while (got_q.size() < exp_q.size() && waited < timeout_cycles) begin
			@(posedge clk);
			waited++;
		end
		if (got_q.size() < exp_q.size()) begin
			fail_timeout("resp_valid");
		end
		// a few more cycles to catch a duplicate
		repeat (3) @(posedge clk);
		#1;
		check_value("result count", got_q.size(), exp_q.size());
		while (exp_q.size() > 0 && got_q.size() > 0) begin
			exp = exp_q.pop_front();
			got = got_q.pop_front();
			check_value("resp.write", got.write, exp.write);
			if (!exp.write) begin
				check_value("resp.rdata", got.rdata, exp.rdata);
			end
		end
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic test_reset_state();
		check_value("req_ready", req_ready, 1'b1);
		check_value("resp_valid", resp_valid, 1'b0);
		check_value("start_fpu", start_fpu, 1'b0);
		check_value("host_req.op", host_req.op, mem_pkg::host_none);
	endtask

	task automatic test_miss_hit();
		int r0;
		int w0;
		r0 = read_count;
		w0 = write_count;
		send_req(32'h0000_0044, 32'h0, 1'b0);
		expect_results();
		check_value("host reads on miss", read_count - r0, 1);
		check_value("host writes on miss", write_count - w0, 0);
		// same line again from the cache
		r0 = read_count;
		send_req(32'h0000_0044, 32'h0, 1'b0);
		expect_results();
		check_value("host reads on hit", read_count - r0, 0);
		check_value("host writes on hit", write_count - w0, 0);
	endtask

	task automatic test_store_load();
		int r0;
		int w0;
		int i;
		r0 = read_count;
		w0 = write_count;
		send_req(32'h0000_0048, 32'hdead_beef, 1'b1);
		expect_results();
		check_value("host writes on store", write_count - w0, 1);
		check_value("host reads on store hit", read_count - r0, 0);
		check_value("host write addr", last_waddr, 32'h0000_0040);
		// new word merged with the other 15 untouched
		for (i = 0; i < mem_pkg::words_per_line; i++) begin
			check_value("host line word", last_wline[i * 32 +: 32], shadow_word(32'h40 + i * 4));
		end
		send_req(32'h0000_0048, 32'h0, 1'b0);
		expect_results();
	endtask

	task automatic test_fpu_start();
		int p0;
		int h0;
		p0 = fpu_pulses;
		h0 = read_count + write_count;
		send_req(fpu_addr, 32'h0000_0001, 1'b1);
		expect_results();
		check_value("start_fpu pulses on store", fpu_pulses - p0, 1);
		check_value("host transactions on control store", read_count + write_count - h0, 0);
		p0 = fpu_pulses;
		send_req(fpu_addr, 32'h0, 1'b0);
		expect_results();
		check_value("start_fpu pulses on load", fpu_pulses - p0, 0);
		check_value("host transactions on control load", read_count + write_count - h0, 0);
	endtask

	task automatic test_backpressure();
		resp_ready = 1'b0;
		// three items fill input register, decoder and result register
		send_req(32'h0000_0080, 32'h0, 1'b0);
		send_req(32'h0000_0084, 32'h1234_5678, 1'b1);
		send_req(32'h0000_0084, 32'h0, 1'b0);
		repeat (4) @(posedge clk);
		#1;
		// every stage full so nothing more gets in
		check_value("req_ready during stall", req_ready, 1'b0);
		check_value("resp_valid during stall", resp_valid, 1'b1);
		// oldest result held at the output
		check_value("resp.rdata during stall", resp.rdata, exp_q[0].rdata);
		resp_ready = 1'b1;
		expect_results();
	endtask

	task automatic test_conflict();
		int r0;
		int n;
		// 0x104 and 0x308 share index 0 with 4 lines
		for (n = 0; n < 4; n++) begin
			r0 = read_count;
			send_req((n % 2 == 0) ? 32'h0000_0104 : 32'h0000_0308, 32'h0, 1'b0);
			expect_results();
			check_value("host reads on conflict", read_count - r0, 1);
		end
	endtask

	task automatic test_random_mix();
		int n;
		logic [31:0] addr;
		for (n = 0; n < 40; n++) begin
			// six lines over four indexes give some evictions
			addr = ($urandom % 96) << 2;
			send_req(addr, $urandom, $urandom % 2);
			if ($urandom % 5 == 0) begin
				resp_ready = 1'b0;
				repeat (1 + $urandom % 4) @(posedge clk);
				#1;
				resp_ready = 1'b1;
			end
		end
		expect_results();
	endtask

	initial begin
		void'($urandom(32'hcf0d_8c6b));
		arst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		resp_ready = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		test_reset_state();
		test_miss_hit();
		test_store_load();
		test_fpu_start();
		test_backpressure();
		test_conflict();
		test_random_mix();
		finish_run();
	end

endmodule

`default_nettype wire

// ==== verilog/line_cache.sv ====
`default_nettype none

module line_cache #(
	parameter int num_lines = 8
) (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic req_valid,
	output logic req_ready,
	input  wire mem_pkg::mem_req_t req,
	output logic res_valid,
	input  wire logic res_ready,
	output mem_pkg::mem_result_t result,
	output mem_pkg::host_req_t host_req,
	input  wire logic [mem_pkg::line_w-1:0] host_rdata,
	input  wire logic host_tx_done,
	input  wire logic host_rd_valid
);

	// address split: tag | index | word select | byte
	localparam int off_w = mem_pkg::line_off_w;
	localparam int idx_w = $clog2(num_lines);
	localparam int tag_w = 32 - off_w - idx_w;
	localparam int sel_w = $clog2(mem_pkg::words_per_line);

	typedef enum logic [1:0] {
		st_idle,
		st_fill,
		st_write,
		st_respond
	} state_e;

	state_e state;
	mem_pkg::mem_req_t req_q;
	logic [mem_pkg::word_w-1:0] rdata_q;
	// merged line for the host write
	logic [mem_pkg::line_w-1:0] wline_q;
	logic [num_lines-1:0] line_ok;
	logic [tag_w-1:0] tags [num_lines];
	logic [mem_pkg::line_w-1:0] lines [num_lines];
	logic [idx_w-1:0] in_idx;
	logic [tag_w-1:0] in_tag;
	logic [sel_w-1:0] in_sel;
	logic [idx_w-1:0] q_idx;
	logic [tag_w-1:0] q_tag;
	logic [sel_w-1:0] q_sel;
	logic [mem_pkg::line_w-1:0] hit_line;
	logic hit;
	logic fill_done;

	function automatic logic [mem_pkg::word_w-1:0] get_word(
		input logic [mem_pkg::line_w-1:0] line,
		input logic [sel_w-1:0] sel
	);
		return line[sel * mem_pkg::word_w +: mem_pkg::word_w];
	endfunction

	function automatic logic [mem_pkg::line_w-1:0] put_word(
		input logic [mem_pkg::line_w-1:0] line,
		input logic [sel_w-1:0] sel,
		input logic [mem_pkg::word_w-1:0] word
	);
		logic [mem_pkg::line_w-1:0] merged;
		merged = line;
		merged[sel * mem_pkg::word_w +: mem_pkg::word_w] = word;
		return merged;
	endfunction

	// incoming request fields
	assign in_sel = req.addr[2 +: sel_w];
	assign in_idx = req.addr[off_w +: idx_w];
	assign in_tag = req.addr[31 -: tag_w];
	// held request fields
	assign q_sel = req_q.addr[2 +: sel_w];
	assign q_idx = req_q.addr[off_w +: idx_w];
	assign q_tag = req_q.addr[31 -: tag_w];

	assign hit_line = lines[in_idx];
	assign hit = line_ok[in_idx] && (tags[in_idx] == in_tag);

	// host read data comes with tx_done
	assign fill_done = host_tx_done && host_rd_valid;

	assign req_ready = state == st_idle;
	assign res_valid = state == st_respond;
	assign result.rdata = rdata_q;
	assign result.write = req_q.write;

	always_comb begin
		host_req.op = mem_pkg::host_none;
		host_req.addr = {req_q.addr[31:off_w], {off_w{1'b0}}};
		host_req.data = '0;
		case (state)
			st_fill: begin
				host_req.op = mem_pkg::host_read;
			end
			st_write: begin
				host_req.op = mem_pkg::host_write;
				host_req.data = wline_q;
			end
			default: begin
				host_req.op = mem_pkg::host_none;
			end
		endcase
	end

	// control: state and line valid bits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			line_ok <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (req_valid) begin
						if (!hit) begin
							// stores also fetch a missing line first
							state <= st_fill;
						end else if (req.write) begin
							state <= st_write;
						end else begin
							state <= st_respond;
						end
					end
				end
				st_fill: begin
					if (fill_done) begin
						line_ok[q_idx] <= 1'b1;
						state <= req_q.write ? st_write : st_respond;
					end
				end
				st_write: begin
					if (host_tx_done) begin
						state <= st_respond;
					end
				end
				default: begin
					if (res_ready) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// data: held request, read word, line store
	always_ff @(posedge clk) begin
		case (state)
			st_idle: begin
				if (req_valid) begin
					req_q <= req;
					rdata_q <= get_word(hit_line, in_sel);
					wline_q <= put_word(hit_line, in_sel, req.wdata);
				end
			end
			st_fill: begin
				if (fill_done) begin
					lines[q_idx] <= host_rdata;
					tags[q_idx] <= q_tag;
					rdata_q <= get_word(host_rdata, q_sel);
					wline_q <= put_word(host_rdata, q_sel, req_q.wdata);
				end
			end
			st_write: begin
				// line updated only once the host has it, never dirty
				if (host_tx_done) begin
					lines[q_idx] <= wline_q;
					rdata_q <= req_q.wdata;
				end
			end
			default: begin
				rdata_q <= rdata_q;
			end
		endcase
	end

	// host request held steady until the controller finishes
	assert property (@(posedge clk) disable iff (!arst_n)
		(host_req.op != mem_pkg::host_none) && !host_tx_done |=> $stable(host_req));

	// read data only shows up for an open line fill
	assert property (@(posedge clk) disable iff (!arst_n)
		host_rd_valid |-> state == st_fill);

endmodule

`default_nettype wire

// ==== verilog/mem_access_decode.sv ====
`default_nettype none

module mem_access_decode #(
	parameter logic [31:0] fpu_start_addr = 32'h1000_0000
) (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic req_valid,
	output logic req_ready,
	input  wire mem_pkg::mem_req_t req,
	output logic cache_valid,
	input  wire logic cache_ready,
	output mem_pkg::mem_req_t cache_req,
	input  wire logic cache_rvalid,
	output logic cache_rready,
	input  wire mem_pkg::mem_result_t cache_result,
	output logic res_valid,
	input  wire logic res_ready,
	output mem_pkg::mem_result_t result,
	output logic start_fpu
);

	logic is_ctrl;
	logic take_ctrl;
	logic take_cache;
	logic res_done;
	// one access outstanding, either kind
	logic busy;
	// outstanding access is the control word
	logic busy_ctrl;
	logic ctrl_write;

	// word compare, byte offset ignored
	assign is_ctrl = req.addr[31:2] == fpu_start_addr[31:2];

	// everything else goes to the cache
	assign cache_req = req;
	assign cache_valid = req_valid && !is_ctrl && !busy;
	assign take_cache = cache_valid && cache_ready;
	assign take_ctrl = req_valid && is_ctrl && !busy;
	assign req_ready = !busy && (is_ctrl || cache_ready);

	// control result is ready at once, cache result when the cache says so
	assign res_valid = busy && (busy_ctrl || cache_rvalid);
	assign cache_rready = busy && !busy_ctrl && res_ready;
	assign res_done = res_valid && res_ready;

	always_comb begin
		if (busy_ctrl) begin
			// control load reads back zero
			result.rdata = '0;
			result.write = ctrl_write;
		end else begin
			result = cache_result;
		end
	end

	// pulse only at the handover, so a stall cannot repeat it
	assign start_fpu = busy && busy_ctrl && ctrl_write && res_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			busy_ctrl <= 1'b0;
			ctrl_write <= 1'b0;
		end else if (take_ctrl || take_cache) begin
			busy <= 1'b1;
			busy_ctrl <= take_ctrl;
			ctrl_write <= req.write;
		end else if (res_done) begin
			busy <= 1'b0;
		end
	end

	// single-cycle pulse tied to a result handover
	assert property (@(posedge clk) disable iff (!arst_n)
		start_fpu |-> (res_valid && res_ready) ##1 !start_fpu);

	// cache only answers a request it got from here
	assert property (@(posedge clk) disable iff (!arst_n)
		cache_rvalid |-> busy && !busy_ctrl);

endmodule

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// data path widths
	localparam int word_w = 32;
	localparam int line_w = 512;
	localparam int words_per_line = 16;
	// byte offset bits inside one host line, 64 bytes per line
	localparam int line_off_w = $clog2(words_per_line * (word_w / 8));

	// op codes of the host memory controller
	typedef enum logic [1:0] {
		host_none  = 2'd0,
		host_read  = 2'd1,
		host_write = 2'd2
	} host_op_e;

	// one access out of the execute/memory register
	typedef struct packed {
		logic [31:0] addr;
		logic [word_w-1:0] wdata;
		logic write;
	} mem_req_t;

	// one finished access back to the pipeline
	typedef struct packed {
		logic [word_w-1:0] rdata;
		logic write;
	} mem_result_t;

	// line request towards the host controller
	// addr is the byte address of the line, low offset bits zero
	typedef struct packed {
		host_op_e op;
		logic [31:0] addr;
		logic [line_w-1:0] data;
	} host_req_t;

endpackage

`default_nettype wire

// ==== verilog/mem_stage.sv ====
`default_nettype none

module mem_stage #(
	parameter int num_lines = 8,
	parameter logic [31:0] fpu_start_addr = 32'h1000_0000
) (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic req_valid,
	output logic req_ready,
	input  wire mem_pkg::mem_req_t req,
	output logic resp_valid,
	input  wire logic resp_ready,
	output mem_pkg::mem_result_t resp,
	output mem_pkg::host_req_t host_req,
	input  wire logic [mem_pkg::line_w-1:0] host_rdata,
	input  wire logic host_tx_done,
	input  wire logic host_rd_valid,
	output logic start_fpu
);

	// input register to decoder
	logic in_valid;
	logic in_ready;
	mem_pkg::mem_req_t in_req;
	// decoder to cache
	logic cache_valid;
	logic cache_ready;
	mem_pkg::mem_req_t cache_req;
	// cache back to decoder
	logic cache_rvalid;
	logic cache_rready;
	mem_pkg::mem_result_t cache_result;
	// decoder to result register
	logic res_valid;
	logic res_ready;
	mem_pkg::mem_result_t result;

	pipe_reg #(
		.payload_t(mem_pkg::mem_req_t)
	) u_in_reg (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(req_valid),
		.in_ready(req_ready),
		.in_data(req),
		.out_valid(in_valid),
		.out_ready(in_ready),
		.out_data(in_req)
	);

	mem_access_decode #(
		.fpu_start_addr(fpu_start_addr)
	) u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(in_valid),
		.req_ready(in_ready),
		.req(in_req),
		.cache_valid(cache_valid),
		.cache_ready(cache_ready),
		.cache_req(cache_req),
		.cache_rvalid(cache_rvalid),
		.cache_rready(cache_rready),
		.cache_result(cache_result),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.result(result),
		.start_fpu(start_fpu)
	);

	line_cache #(
		.num_lines(num_lines)
	) u_cache (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(cache_valid),
		.req_ready(cache_ready),
		.req(cache_req),
		.res_valid(cache_rvalid),
		.res_ready(cache_rready),
		.result(cache_result),
		.host_req(host_req),
		.host_rdata(host_rdata),
		.host_tx_done(host_tx_done),
		.host_rd_valid(host_rd_valid)
	);

	pipe_reg #(
		.payload_t(mem_pkg::mem_result_t)
	) u_out_reg (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(res_valid),
		.in_ready(res_ready),
		.in_data(result),
		.out_valid(resp_valid),
		.out_ready(resp_ready),
		.out_data(resp)
	);

endmodule

`default_nettype wire

// ==== verilog/pipe_reg.sv ====
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic in_valid,
	output logic in_ready,
	input  wire payload_t in_data,
	output logic out_valid,
	input  wire logic out_ready,
	output payload_t out_data
);

	// free slot, or the held item leaves this cycle
	assign in_ready = !out_valid || out_ready;

	// occupancy flag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	// payload, loaded only on a transfer
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

	// a stalled item stays put until taken
	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire
